//--- Bender.yml
package:
  name: vstrm

sources:
  - include_dirs:
      - .
    files:
      - vstrm_pkg.sv
      - vstrm_read_cache.sv
      - vstrm_fill.sv
      - vstrm_fetch.sv
      - vstrm_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vstrm_mem.sv
      - tb_vstrm_top.sv

//--- flist.f
+incdir+.
vstrm_pkg.sv
vstrm_read_cache.sv
vstrm_fill.sv
vstrm_fetch.sv
vstrm_top.sv
tb_vstrm_mem.sv
tb_vstrm_top.sv

//--- tb_vstrm_mem.sv
`include "vstrm_config.svh"

module tb_vstrm_mem import vstrm_pkg::*; (
	input  logic                     rclk,
	input  logic                     rst,
	input  vstrm_mem_req_t           mem_req,
	output logic                     mem_ack,
	output logic [`VSTRM_LINE_W-1:0] mem_dat
);

	timeunit 1ns;
	timeprecision 1ps;

	// Seed for the answer latency, so every run sees the same delays
	integer seed;

	// ======================================================================
	// Data rule
	// ======================================================================

	// Each line is four 32-bit words and the highest word holds A+12
	function automatic logic [`VSTRM_LINE_W-1:0] line_data(input logic [31:0] a);
		return {a + 32'd12, a + 32'd8, a + 32'd4, a};
	endfunction

	// ======================================================================
	// Request server
	// ======================================================================

	// The request strobe is a whole clock wide, so the falling edge sees
	// it settled; the answer also goes out on a falling edge
	initial begin
		logic [31:0] adr;
		int          delay;
		seed = 60281;
		mem_ack = 1'b0;
		mem_dat = '0;
		forever begin
			@(negedge rclk);
			if (!rst && mem_req.req) begin
				adr = mem_req.adr;
				// Between one and eight cycles of memory latency
				delay = ($random(seed) & 7) + 1;
				repeat (delay) @(negedge rclk);
				mem_ack = 1'b1;
				mem_dat = line_data(adr);
				@(negedge rclk);
				mem_ack = 1'b0;
			end
		end
	end

endmodule

//--- tb_vstrm_top.sv
`include "vstrm_config.svh"

module tb_vstrm_top import vstrm_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic                     rclk;
	logic                     rst;
	logic                     start;
	logic [`VSTRM_ADR_W-1:0]  base;
	logic [`VSTRM_CNT_W-1:0]  count;
	logic                     out_vld;
	logic [`VSTRM_LINE_W-1:0] out_dat;
	logic                     busy;
	logic                     done;
	vstrm_mem_req_t           mem_req;
	logic                     mem_ack;
	logic [`VSTRM_LINE_W-1:0] mem_dat;

	// Scoreboard with the next line address due on the stream and the event counters
	logic [31:0] exp_adr;
	int          exp_cnt;
	int          exp_req;
	int          vld_cnt;
	int          req_cnt;
	int          done_cnt;

	// out_vld one cycle back, for the done timing
	logic        vld_d;

	// Error tallies for the closing line
	int err_val;
	int err_oth;
	int err_tmo;

	vstrm_top dut_i (
		.rclk    (rclk),
		.rst     (rst),
		.start   (start),
		.base    (base),
		.count   (count),
		.out_vld (out_vld),
		.out_dat (out_dat),
		.busy    (busy),
		.done    (done),
		.mem_req (mem_req),
		.mem_ack (mem_ack),
		.mem_dat (mem_dat)
	);

	tb_vstrm_mem mem_i (
		.rclk    (rclk),
		.rst     (rst),
		.mem_req (mem_req),
		.mem_ack (mem_ack),
		.mem_dat (mem_dat)
	);

	// 100 ns period
	initial begin
		rclk = 1'b0;
		forever #50 rclk = ~rclk;
	end

	// Expected line for address a holds four ascending words with a at the bottom
	function automatic logic [127:0] expect_line(input logic [31:0] a);
		return {a + 32'd12, a + 32'd8, a + 32'd4, a};
	endfunction

	// ======================================================================
	// Scoreboard and checking assertions
	// ======================================================================

	// Each emitted line moves the expected address on by one line
	always @(posedge rclk) begin
		vld_d <= out_vld;
		if (out_vld) begin
			exp_adr <= exp_adr + 32'd16;
			vld_cnt <= vld_cnt + 1;
		end
		if (mem_req.req) begin
			req_cnt <= req_cnt + 1;
		end
		if (done) begin
			done_cnt <= done_cnt + 1;
		end
	end

	a_line_dat: assert property (
		@(posedge rclk) disable iff (rst)
		out_vld |-> (out_dat == expect_line(exp_adr))
	) else begin
		err_val++;
		$display("Fail out_dat exp %h got %h",
			expect_line($sampled(exp_adr)), $sampled(out_dat));
	end

	// With one line in flight a miss always asks for the line due next
	a_req_adr: assert property (
		@(posedge rclk) disable iff (rst)
		mem_req.req |-> (mem_req.adr == exp_adr)
	) else begin
		err_val++;
		$display("Fail mem_req.adr exp %h got %h", $sampled(exp_adr), $sampled(mem_req.adr));
	end

	// By the done pulse every line and every fill has been seen
	a_vld_count: assert property (
		@(posedge rclk) disable iff (rst)
		done |-> (vld_cnt == exp_cnt)
	) else begin
		err_val++;
		$display("Fail out_vld count exp %h got %h", $sampled(exp_cnt), $sampled(vld_cnt));
	end

	a_req_count: assert property (
		@(posedge rclk) disable iff (rst)
		done |-> (req_cnt == exp_req)
	) else begin
		err_val++;
		$display("Fail mem_req count exp %h got %h", $sampled(exp_req), $sampled(req_cnt));
	end

	// Every stream here has lines, so done comes one cycle after the last one
	a_done_after_vld: assert property (
		@(posedge rclk) disable iff (rst)
		done |-> vld_d
	) else begin
		err_val++;
		$display("Fail out_vld before done exp %h got %h", 1'b1, $sampled(vld_d));
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	// Hold reset for 8 cycles, then outputs must be quiet
	task automatic apply_reset();
		rst = 1'b1;
		repeat (8) @(negedge rclk);
		rst = 1'b0;
		@(negedge rclk);
		a_rst_quiet: assert (!busy && !out_vld && !done && !mem_req.req) else begin
			err_oth++;
			$display("Outputs were not quiet after reset");
		end
	endtask

	// Poll done on falling edges, where it is settled
	task automatic wait_done(input string name);
		int n;
		n = 0;
		@(negedge rclk);
		while (!done && n < 2000) begin
			@(negedge rclk);
			n++;
		end
		if (!done) begin
			err_tmo++;
			$display("Timeout: the %s stream never finished", name);
		end
	endtask

	// One stream from b over n lines, expecting n_req fills
	// With poke set, a second start arrives mid-stream and must be ignored
	task automatic run_stream(input logic [31:0] b, input int n, input int n_req,
		input bit poke, input string name);
		@(negedge rclk);
		vld_cnt = 0;
		req_cnt = 0;
		done_cnt = 0;
		exp_adr = b;
		exp_cnt = n;
		exp_req = n_req;
		base = b;
		count = n[15:0];
		start = 1'b1;
		@(negedge rclk);
		start = 1'b0;
		if (poke) begin
			repeat (10) @(negedge rclk);
			a_busy_poke: assert (busy) else begin
				err_oth++;
				$display("Reader was idle when the second start was sent");
			end
			base = 32'h0000_5000;
			count = 16'd3;
			start = 1'b1;
			@(negedge rclk);
			start = 1'b0;
		end
		wait_done(name);
		// A few quiet cycles to catch a second done
		repeat (4) @(negedge rclk);
		a_one_done: assert (done_cnt == 1) else begin
			err_val++;
			$display("Fail done count exp %h got %h", 1, done_cnt);
		end
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		rst = 1'b1;
		start = 1'b0;
		base = '0;
		count = '0;
		exp_adr = '0;
		exp_cnt = 0;
		exp_req = 0;
		vld_cnt = 0;
		req_cnt = 0;
		done_cnt = 0;
		vld_d = 1'b0;
		err_val = 0;
		err_oth = 0;
		err_tmo = 0;
		apply_reset();

		// Every line misses once in the cold cache
		run_stream(32'h0000_1000, 16, 16, 1'b0, "cold 0x1000");
		// The same lines again all hit
		run_stream(32'h0000_1000, 16, 0, 1'b0, "warm 0x1000");
		// 0x2000 lands on the same indices and evicts them
		run_stream(32'h0000_2000, 16, 16, 1'b0, "alias 0x2000");
		run_stream(32'h0000_1000, 16, 16, 1'b0, "re-read 0x1000");
		// The cache is warm here and reset must empty it
		apply_reset();
		run_stream(32'h0000_1000, 16, 16, 1'b0, "post-reset 0x1000");
		run_stream(32'h0000_3000, 8, 8, 1'b1, "start-while-busy 0x3000");

		$display("Errors: value %0d, other %0d, timeout %0d", err_val, err_oth, err_tmo);
		if (err_val + err_oth + err_tmo == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- vstrm_config.svh
`ifndef VSTRM_CONFIG_SVH
`define VSTRM_CONFIG_SVH

// ======================================================================
// Video stream read path geometry
// ======================================================================

// Byte address width of the memory port
`define VSTRM_ADR_W 32

// One cache line, which is also one memory transfer
`define VSTRM_LINE_W 128

// 256 lines in the direct-mapped read cache
`define VSTRM_IDX_W 8

// Byte offset inside a line (16 bytes per line)
`define VSTRM_OFS_W 4

// Whatever is left above index and offset is the tag
`define VSTRM_TAG_W (`VSTRM_ADR_W - `VSTRM_IDX_W - `VSTRM_OFS_W)

// Stream length counter, in lines
`define VSTRM_CNT_W 16

`endif

//--- vstrm_fetch.sv
`include "vstrm_config.svh"

module vstrm_fetch import vstrm_pkg::*; (
	input  logic                     rclk,
	input  logic                     rst,
	input  logic                     start,
	input  logic [`VSTRM_ADR_W-1:0]  base,
	input  logic [`VSTRM_CNT_W-1:0]  count,
	output vstrm_adr_u               rd_adr,
	input  logic [`VSTRM_LINE_W-1:0] rdat,
	input  logic                     hit,
	output logic                     fill_req,
	input  logic                     fill_done,
	output logic                     out_vld,
	output logic [`VSTRM_LINE_W-1:0] out_dat,
	output logic                     busy,
	output logic                     done
);

	// Bytes per line, the address step between consecutive lookups
	localparam int unsigned LINE_BYTES = 1 << `VSTRM_OFS_W;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WAIT1,
		ST_DECIDE,
		ST_FILLW,
		ST_FINISH
	} fetch_state_e;

	fetch_state_e            state;
	fetch_state_e            state_nxt;
	logic [`VSTRM_CNT_W-1:0] rem;
	vstrm_adr_u              cur_adr;
	logic                    take_start;
	logic                    emit;
	logic                    miss;
	logic                    last;

	// A start only counts while nothing is running
	assign take_start = (state == ST_IDLE) && start;

	// Decision cycle outcomes; cache output is settled by now
	assign emit = (state == ST_DECIDE) && hit;
	assign miss = (state == ST_DECIDE) && !hit;

	// The line being decided is the final one of the stream
	assign last = (rem == `VSTRM_CNT_W'(1));

	// ======================================================================
	// Next state
	// ======================================================================

	always_comb begin
		state_nxt = state;
		case (state)
		ST_IDLE: begin
			// An empty stream goes straight to the done pulse
			if (start) begin
				state_nxt = (count == '0) ? ST_FINISH : ST_LOOKUP;
			end
		end
		// Address is on rd_adr during lookup; the cache registers it at the end
		ST_LOOKUP: state_nxt = ST_WAIT1;
		// Cache reads its arrays at the end of this cycle
		ST_WAIT1: state_nxt = ST_DECIDE;
		ST_DECIDE: begin
			if (!hit) begin
				state_nxt = ST_FILLW;
			end else if (last) begin
				state_nxt = ST_FINISH;
			end else begin
				state_nxt = ST_LOOKUP;
			end
		end
		ST_FILLW: begin
			// Retry the same line once it is in the cache
			if (fill_done) begin
				state_nxt = ST_LOOKUP;
			end
		end
		ST_FINISH: state_nxt = ST_IDLE;
		default: state_nxt = ST_IDLE;
		endcase
	end

	// ======================================================================
	// Control registers
	// ======================================================================

	always_ff @(posedge rclk) begin
		if (rst) begin
			state <= ST_IDLE;
			rem <= '0;
			out_vld <= 1'b0;
			fill_req <= 1'b0;
			done <= 1'b0;
		end else begin
			state <= state_nxt;
			out_vld <= emit;
			fill_req <= miss;
			// Finish is entered with the last out_vld, so done lands one later
			done <= (state == ST_FINISH);
			if (take_start) begin
				rem <= count;
			end else if (emit) begin
				rem <= rem - 1'b1;
			end
		end
	end

	// ======================================================================
	// Address and data
	// ======================================================================

	// Step to the next line on every emitted line, so the new address
	// is already on rd_adr in the cycle after the hit
	always_ff @(posedge rclk) begin
		if (take_start) begin
			cur_adr.word <= base;
		end else if (emit) begin
			cur_adr.word <= cur_adr.word + `VSTRM_ADR_W'(LINE_BYTES);
		end
	end

	// Output line is the cache data from the decision cycle
	always_ff @(posedge rclk) begin
		if (emit) begin
			out_dat <= rdat;
		end
	end

	// Held steady for the whole lookup, as the cache needs it
	assign rd_adr = cur_adr;
	assign busy = (state != ST_IDLE);

	// Lines only leave while a stream is in progress
	a_vld_in_busy: assert property (
		@(posedge rclk) disable iff (rst)
		out_vld |-> busy
	);

endmodule

//--- vstrm_fill.sv
`include "vstrm_config.svh"

module vstrm_fill import vstrm_pkg::*; (
	input  logic                     rclk,
	input  logic                     rst,
	input  logic                     fill_req,
	input  vstrm_adr_u               fill_adr,
	output vstrm_mem_req_t           mem_req,
	input  logic                     mem_ack,
	input  logic [`VSTRM_LINE_W-1:0] mem_dat,
	output vstrm_cache_wr_t          cache_wr,
	output logic                     fill_done
);

	typedef enum logic {
		FS_IDLE,
		FS_WAIT
	} fill_state_e;

	fill_state_e              state;
	logic                     req_q;
	logic                     wr_q;
	vstrm_adr_u               adr_q;
	vstrm_adr_u               adr_aligned;
	logic [`VSTRM_LINE_W-1:0] dat_q;

	// Drop the byte offset so memory and cache both see a line address
	always_comb begin
		adr_aligned = fill_adr;
		adr_aligned.f.ofs = '0;
	end

	// ======================================================================
	// Control
	// ======================================================================

	// Idle until the reader misses, then wait for the memory answer
	always_ff @(posedge rclk) begin
		if (rst) begin
			state <= FS_IDLE;
			req_q <= 1'b0;
			wr_q <= 1'b0;
		end else begin
			// Request and write are single-cycle strobes by default
			req_q <= 1'b0;
			wr_q <= 1'b0;
			case (state)
			FS_IDLE: begin
				if (fill_req) begin
					req_q <= 1'b1;
					state <= FS_WAIT;
				end
			end
			FS_WAIT: begin
				// Latency is open-ended; mem_ack ends the wait
				if (mem_ack) begin
					wr_q <= 1'b1;
					state <= FS_IDLE;
				end
			end
			default: state <= FS_IDLE;
			endcase
		end
	end

	// ======================================================================
	// Payload
	// ======================================================================

	// Line address is taken with the miss and held through the write
	always_ff @(posedge rclk) begin
		if ((state == FS_IDLE) && fill_req) begin
			adr_q <= adr_aligned;
		end
	end

	// Returned line is captured on the acknowledge cycle
	always_ff @(posedge rclk) begin
		if ((state == FS_WAIT) && mem_ack) begin
			dat_q <= mem_dat;
		end
	end

	assign mem_req = '{req: req_q, adr: adr_q.word};
	assign cache_wr = '{wr: wr_q, adr: adr_q, dat: dat_q};

	// Completion goes out together with the cache write
	assign fill_done = wr_q;

	// The reader keeps one miss outstanding at a time
	a_no_req_while_wait: assert property (
		@(posedge rclk) disable iff (rst)
		fill_req |-> (state == FS_IDLE)
	);

	// Memory only answers a request that this engine issued
	a_no_ack_while_idle: assert property (
		@(posedge rclk) disable iff (rst)
		mem_ack |-> (state == FS_WAIT)
	);

endmodule

//--- vstrm_pkg.sv
`include "vstrm_config.svh"

package vstrm_pkg;

	// ======================================================================
	// Address decoding
	// ======================================================================

	// Field view of a byte address as the cache sees it
	typedef struct packed {
		logic [`VSTRM_TAG_W-1:0] tag;
		logic [`VSTRM_IDX_W-1:0] idx;
		logic [`VSTRM_OFS_W-1:0] ofs;
	} vstrm_adr_fields_t;

	// The same 32-bit word is either a plain byte address or
	// a tag/index/offset triple, depending on who looks at it
	typedef union packed {
		logic [`VSTRM_ADR_W-1:0] word;
		vstrm_adr_fields_t       f;
	} vstrm_adr_u;

	// ======================================================================
	// Transfers between blocks
	// ======================================================================

	// Cache write port, driven by the fill engine
	// Strobe, line address and line data, 161 bits in all
	typedef struct packed {
		logic                     wr;
		vstrm_adr_u               adr;
		logic [`VSTRM_LINE_W-1:0] dat;
	} vstrm_cache_wr_t;

	// Read request towards the memory controller port
	// The address is always line aligned, 33 bits in all
	typedef struct packed {
		logic                    req;
		logic [`VSTRM_ADR_W-1:0] adr;
	} vstrm_mem_req_t;

endpackage

//--- vstrm_read_cache.sv
`include "vstrm_config.svh"

module vstrm_read_cache import vstrm_pkg::*; (
	input  logic                     rclk,
	input  logic                     rst,
	input  vstrm_cache_wr_t          wr_in,
	input  vstrm_adr_u               radr,
	output logic [`VSTRM_LINE_W-1:0] rdat,
	output logic                     hit
);

	localparam int unsigned LINES = 1 << `VSTRM_IDX_W;

	// ======================================================================
	// Storage
	// ======================================================================

	// Line data, meant to land in block RAM
	logic [`VSTRM_LINE_W-1:0] lines [LINES];

	// Tag per line, kept apart so it can sit in distributed RAM
	logic [`VSTRM_TAG_W-1:0] tags [LINES];

	// One valid bit per line; this is the only part that reset touches
	logic [LINES-1:0] valid;

	// Read pipeline registers
	vstrm_adr_u              radr_r;
	logic [`VSTRM_TAG_W-1:0] tag_q;
	logic                    vld_q;

	// Writes from the fill engine go straight into both arrays
	always_ff @(posedge rclk) begin
		if (wr_in.wr) begin
			lines[wr_in.adr.f.idx] <= wr_in.dat;
			tags[wr_in.adr.f.idx] <= wr_in.adr.f.tag;
		end
	end

	// A written line becomes valid; reset invalidates the whole cache
	always_ff @(posedge rclk) begin
		if (rst) begin
			valid <= '0;
		end else if (wr_in.wr) begin
			valid[wr_in.adr.f.idx] <= 1'b1;
		end
	end

	// ======================================================================
	// Two-stage read
	// ======================================================================

	// First edge captures the address the reader is holding
	always_ff @(posedge rclk) begin
		radr_r <= radr;
	end

	// Second edge reads data and tag at the registered index
	// A write one cycle earlier is already in the arrays here
	always_ff @(posedge rclk) begin
		rdat <= lines[radr_r.f.idx];
		tag_q <= tags[radr_r.f.idx];
	end

	// The valid bit travels alongside the tag
	always_ff @(posedge rclk) begin
		if (rst) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= valid[radr_r.f.idx];
		end
	end

	// Compare against the registered address, which still matches as long
	// as the reader holds rd_adr steady across the lookup
	always_comb begin
		hit = vld_q && (tag_q == radr_r.f.tag);
	end

	// The fill engine only ever writes whole, aligned lines
	a_wr_aligned: assert property (
		@(posedge rclk) disable iff (rst)
		wr_in.wr |-> (wr_in.adr.f.ofs == '0)
	);

endmodule

//--- vstrm_top.sv
`include "vstrm_config.svh"

module vstrm_top import vstrm_pkg::*; (
	input  logic                     rclk,
	input  logic                     rst,
	input  logic                     start,
	input  logic [`VSTRM_ADR_W-1:0]  base,
	input  logic [`VSTRM_CNT_W-1:0]  count,
	output logic                     out_vld,
	output logic [`VSTRM_LINE_W-1:0] out_dat,
	output logic                     busy,
	output logic                     done,
	output vstrm_mem_req_t           mem_req,
	input  logic                     mem_ack,
	input  logic [`VSTRM_LINE_W-1:0] mem_dat
);

	// ======================================================================
	// Internal connections
	// ======================================================================

	// Reader to cache, also the miss address for the fill engine
	vstrm_adr_u rd_adr;

	// Cache lookup result back to the reader
	logic [`VSTRM_LINE_W-1:0] c_rdat;
	logic                     c_hit;

	// Miss handshake between reader and fill engine
	logic fill_req;
	logic fill_done;

	// Fill engine writing returned lines into the cache
	vstrm_cache_wr_t cache_wr;

	// Stream reader
	vstrm_fetch fetch_i (
		.rclk      (rclk),
		.rst       (rst),
		.start     (start),
		.base      (base),
		.count     (count),
		.rd_adr    (rd_adr),
		.rdat      (c_rdat),
		.hit       (c_hit),
		.fill_req  (fill_req),
		.fill_done (fill_done),
		.out_vld   (out_vld),
		.out_dat   (out_dat),
		.busy      (busy),
		.done      (done)
	);

	// Line cache, single clock
	vstrm_read_cache cache_i (
		.rclk  (rclk),
		.rst   (rst),
		.wr_in (cache_wr),
		.radr  (rd_adr),
		.rdat  (c_rdat),
		.hit   (c_hit)
	);

	// Miss handler; it takes the address the reader is holding
	vstrm_fill fill_i (
		.rclk      (rclk),
		.rst       (rst),
		.fill_req  (fill_req),
		.fill_adr  (rd_adr),
		.mem_req   (mem_req),
		.mem_ack   (mem_ack),
		.mem_dat   (mem_dat),
		.cache_wr  (cache_wr),
		.fill_done (fill_done)
	);

endmodule
